/* rbm_recon.f */
+incdir+sim
source/rbm_pkg.sv
source/rbm_sequencer.sv
source/visible_unit.sv
source/sample_collector.sv
source/rbm_recon.sv
sim/tb_rbm_recon.sv

/* Bender.yml */
package:
  name: rbm_recon

sources:
  - files:
      - source/rbm_pkg.sv
      - source/rbm_sequencer.sv
      - source/visible_unit.sv
      - source/sample_collector.sv
      - source/rbm_recon.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_rbm_recon.sv

/* sim/rbm_model.svh */
// ==============================
// Reference model of the reconstruct run
// Weight, bias and LFSR copies
// Clamp, sigmoid, LFSR step and full run
// ==============================

`ifndef RBM_MODEL_SVH
`define RBM_MODEL_SVH

int ref_weight [rbm_pkg::NUM_VISIBLE][rbm_pkg::NUM_HIDDEN];
int ref_bias [rbm_pkg::NUM_VISIBLE];
logic [15:0] ref_lfsr [rbm_pkg::NUM_VISIBLE];

// Same state as the DUT right after reset
task automatic reset_model_state();
    for (int k = 0; k < rbm_pkg::NUM_VISIBLE; k++) begin
        ref_bias[k] = 0;
        ref_lfsr[k] = 16'hACE1 ^ 16'(k);
        for (int c = 0; c < rbm_pkg::NUM_HIDDEN; c++) begin
            ref_weight[k][c] = 0;
        end
    end
endtask

task automatic store_param(input rbm_pkg::param_target_e target, input int row, input int col,
                           input logic [7:0] data);
    if (target == rbm_pkg::WEIGHT) begin
        ref_weight[row][col] = int'($signed(data));
    end else begin
        ref_bias[row] = int'($signed(data));
    end
endtask

function automatic int clamp_to_byte(input int value);
    if (value > 127) return 127;
    if (value < -128) return -128;
    return value;
endfunction

// Piecewise sigmoid, mirrored below zero
function automatic logic [15:0] sigmoid_value(input int clamped);
    int a;
    int f;
    a = (clamped < 0) ? -clamped : clamped;
    if (a >= 80) f = 65535;
    else if (a >= 38) f = 128 * a + 55296;
    else if (a >= 16) f = 512 * a + 40960;
    else f = 1024 * a + 32768;
    if (clamped < 0) f = 65536 - f;
    return 16'(f);
endfunction

function automatic logic [15:0] lfsr16_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// One full run; advances every unit LFSR once
task automatic predict_visible(input logic [15:0] hid, output logic [15:0] vis);
    int pre;
    logic [15:0] sig;
    for (int k = 0; k < rbm_pkg::NUM_VISIBLE; k++) begin
        pre = ref_bias[k];
        for (int c = 0; c < rbm_pkg::NUM_HIDDEN; c++) begin
            if (hid[c]) pre += ref_weight[k][c];
        end
        sig = sigmoid_value(clamp_to_byte(pre));
        vis[k] = (sig > ref_lfsr[k]);
        ref_lfsr[k] = lfsr16_next(ref_lfsr[k]);
    end
endtask

`endif

/* sim/tb_rbm_recon.sv */
// ==============================
// Testbench for the RBM reconstruct top level
// Clock, reset, random parameters and hidden vectors
// Run loop with latency, pulse and visible checks
// ==============================

`timescale 1ns/100ps
`default_nettype none

module tb_rbm_recon;

    localparam int DRIVE_DELAY  = 10;
    localparam int WAIT_LIMIT   = 100;
    localparam int DONE_LATENCY = 20;

    logic                  clk;
    logic                  reset_n;
    logic                  start;
    logic [15:0]           hidden;
    logic                  param_we;
    rbm_pkg::param_write_t param;
    logic                  busy;
    logic                  done;
    logic [15:0]           visible;
    logic [31:0]           rng_state;
    logic [31:0]           rnd;
    logic [31:0]           rnd_b;
    int                    value_errors;
    int                    other_errors;

    `include "rbm_model.svh"

    rbm_recon u_dut (
        .clk      (clk),
        .reset_n  (reset_n),
        .start    (start),
        .hidden   (hidden),
        .param_we (param_we),
        .param    (param),
        .busy     (busy),
        .done     (done),
        .visible  (visible)
    );

    always #50 clk = ~clk;

    // Hard stop in case a loop misbehaves
    initial begin
        #2_000_000;
        $display("Simulation time limit reached, run aborted");
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ==============================
    // Helpers
    // ==============================

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h80200003;
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            rng_state = galois_step(rng_state);
            value = {value[30:0], rng_state[0]};
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got == expected) else begin
            $display("ERR %s: got %h expected %h", name, got, expected);
            value_errors++;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        assert (!busy) else begin
            $display("DUT stayed busy for %0d cycles", WAIT_LIMIT);
            other_errors++;
        end
    endtask

    task automatic write_param(input rbm_pkg::param_target_e target, input int row,
                               input int col, input logic [7:0] data);
        param_we     = 1'b1;
        param.target = target;
        param.row    = 4'(row);
        param.col    = 4'(col);
        param.data   = data;
        next_cycle();
        param_we = 1'b0;
        store_param(target, row, col, data);
    endtask

    // Random or uniform values for every weight and bias
    task automatic load_params(input bit use_random, input logic [7:0] w, input logic [7:0] b);
        logic [31:0] v;
        wait_idle();
        for (int r = 0; r < rbm_pkg::NUM_VISIBLE; r++) begin
            for (int c = 0; c < rbm_pkg::NUM_HIDDEN; c++) begin
                v = w;
                if (use_random) draw_bits(8, v);
                write_param(rbm_pkg::WEIGHT, r, c, v[7:0]);
            end
            v = b;
            if (use_random) draw_bits(8, v);
            write_param(rbm_pkg::BIAS, r, 0, v[7:0]);
        end
    endtask

    // One run, optionally with a second start pulsed while busy
    task automatic run_checked(input logic [15:0] vec, input logic [15:0] extra_vec,
                               input bit extra_start, input string label);
        logic [15:0] expected;
        int n;
        int done_at;
        int done_count;
        predict_visible(vec, expected);
        wait_idle();
        start  = 1'b1;
        hidden = vec;
        next_cycle();
        start = 1'b0;
        n = 0;
        done_at = 0;
        done_count = 0;
        while (n < WAIT_LIMIT && (done_at == 0 || n < done_at + 10)) begin
            if (extra_start && n == 4) begin
                start  = 1'b1;
                hidden = extra_vec;
            end
            next_cycle();
            n++;
            start = 1'b0;
            if (n <= 18) check_value("busy", busy, n < 18);
            if (done) begin
                done_count++;
                if (done_at == 0) done_at = n;
            end
        end
        assert (done_at != 0) else begin
            $display("%s: no done pulse within %0d cycles", label, WAIT_LIMIT);
            other_errors++;
        end
        assert (done_at == 0 || done_count == 1) else begin
            $display("%s: done was high for %0d cycles instead of one", label, done_count);
            other_errors++;
        end
        if (done_at != 0) check_value("done latency", done_at, DONE_LATENCY);
        check_value("visible", visible, expected);
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        clk          = 1'b0;
        reset_n      = 1'b0;
        start        = 1'b0;
        hidden       = '0;
        param_we     = 1'b0;
        param        = '0;
        rng_state    = 32'h09a6ef2d;
        value_errors = 0;
        other_errors = 0;
        reset_model_state();

        repeat (16) @(posedge clk);
        #(DRIVE_DELAY);
        reset_n = 1'b1;
        check_value("busy", busy, 0);
        check_value("done", done, 0);
        check_value("visible", visible, 0);

        // All parameters still zero, sigmoid sits at one half
        draw_bits(16, rnd);
        run_checked(rnd[15:0], '0, 1'b0, "zero params");

        load_params(1'b1, '0, '0);
        for (int i = 0; i < 40; i++) begin
            draw_bits(16, rnd);
            run_checked(rnd[15:0], '0, 1'b0, "random run");
        end

        // Saturation at both ends
        load_params(1'b0, 8'h7f, 8'h7f);
        run_checked(16'hffff, '0, 1'b0, "positive saturation");
        load_params(1'b0, 8'h80, 8'h80);
        run_checked(16'hffff, '0, 1'b0, "negative saturation");
        check_value("visible", visible, 0);

        // Start while busy must not trigger a second run
        load_params(1'b1, '0, '0);
        draw_bits(16, rnd);
        draw_bits(16, rnd_b);
        run_checked(rnd[15:0], rnd_b[15:0], 1'b1, "start while busy");
        draw_bits(16, rnd);
        run_checked(rnd[15:0], '0, 1'b0, "run after ignored start");

        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/rbm_recon.sv */
// ==============================
// RBM reconstruct top level
// Sequencer, sixteen visible units, collector
// ==============================

`timescale 1ns/100ps
`default_nettype none

module rbm_recon (
    input  wire                                clk,
    input  wire                                reset_n,
    input  wire                                start,
    input  wire  [rbm_pkg::NUM_HIDDEN-1:0]     hidden,
    input  wire                                param_we,
    input  wire  rbm_pkg::param_write_t        param,
    output logic                               busy,
    output logic                               done,
    output logic [rbm_pkg::NUM_VISIBLE-1:0]    visible
);

    rbm_pkg::unit_ctrl_t                            ctrl;
    rbm_pkg::unit_feed_t [rbm_pkg::NUM_VISIBLE-1:0] feed;
    logic [rbm_pkg::NUM_VISIBLE-1:0]                sample;
    logic [rbm_pkg::NUM_VISIBLE-1:0]                sample_valid;

    rbm_sequencer u_sequencer (
        .clk      (clk),
        .reset_n  (reset_n),
        .start    (start),
        .hidden   (hidden),
        .param_we (param_we),
        .param    (param),
        .busy     (busy),
        .ctrl     (ctrl),
        .feed     (feed)
    );

    // One neuron per visible bit, each with its own seed
    for (genvar i = 0; i < rbm_pkg::NUM_VISIBLE; i++) begin : g_unit
        visible_unit #(
            .UNIT_INDEX (i)
        ) u_unit (
            .clk          (clk),
            .reset_n      (reset_n),
            .ctrl         (ctrl),
            .feed         (feed[i]),
            .sample       (sample[i]),
            .sample_valid (sample_valid[i])
        );
    end

    sample_collector u_collector (
        .clk          (clk),
        .reset_n      (reset_n),
        .sample       (sample),
        .sample_valid (sample_valid),
        .visible      (visible),
        .done         (done)
    );

endmodule

`default_nettype wire

/* source/sample_collector.sv */
// ==============================
// Sample collector
// Latches the visible vector and pulses done
// ==============================

`timescale 1ns/100ps
`default_nettype none

module sample_collector (
    input  wire                               clk,
    input  wire                               reset_n,
    input  wire  [rbm_pkg::NUM_VISIBLE-1:0]   sample,
    input  wire  [rbm_pkg::NUM_VISIBLE-1:0]   sample_valid,
    output logic [rbm_pkg::NUM_VISIBLE-1:0]   visible,
    output logic                              done
);

    logic all_valid;

    // Units run in lockstep, so all report together
    assign all_valid = &sample_valid;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            visible <= '0;
            done    <= 1'b0;
        end else begin
            done <= all_valid;
            // Held until the next run completes
            if (all_valid) begin
                visible <= sample;
            end
        end
    end

endmodule

`default_nettype wire

/* source/visible_unit.sv */
// ==============================
// One visible neuron
// Weight accumulation and bias add
// Clamp and piecewise-linear sigmoid
// LFSR sampling of the visible bit
// ==============================

`timescale 1ns/100ps
`default_nettype none

module visible_unit #(
    parameter int UNIT_INDEX = 0
) (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire  rbm_pkg::unit_ctrl_t  ctrl,
    input  wire  rbm_pkg::unit_feed_t  feed,
    output logic                       sample,
    output logic                       sample_valid
);

    localparam logic [rbm_pkg::PROB_W-1:0] SEED =
        rbm_pkg::LFSR_SEED_BASE ^ rbm_pkg::PROB_W'(UNIT_INDEX);

    localparam int EXT_W = rbm_pkg::ACC_W - rbm_pkg::DATA_W;

    logic signed [rbm_pkg::ACC_W-1:0]  acc;
    logic signed [rbm_pkg::ACC_W-1:0]  pre;
    logic signed [rbm_pkg::ACC_W-1:0]  weight_ext;
    logic signed [rbm_pkg::ACC_W-1:0]  bias_ext;
    logic signed [rbm_pkg::DATA_W-1:0] clamped;
    logic [rbm_pkg::DATA_W-1:0]        mag;
    logic [rbm_pkg::PROB_W-1:0]        f_pos;
    logic [rbm_pkg::PROB_W-1:0]        prob;
    logic [rbm_pkg::PROB_W-1:0]        sig;
    logic [rbm_pkg::PROB_W-1:0]        lfsr;
    logic                              lfsr_fb;
    logic                              pre_valid;
    logic                              sig_valid;

    assign weight_ext = {{EXT_W{feed.weight[rbm_pkg::DATA_W-1]}}, feed.weight};
    assign bias_ext   = {{EXT_W{feed.bias[rbm_pkg::DATA_W-1]}}, feed.bias};

    // ==============================
    // Accumulate and bias
    // ==============================

    // One column per cycle, only where the hidden bit is set
    always_ff @(posedge clk) begin
        if (ctrl.clear) begin
            acc <= '0;
        end else if (ctrl.accumulate && ctrl.hidden_bit) begin
            acc <= acc + weight_ext;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.finish) begin
            pre <= acc + bias_ext;
        end
    end

    // ==============================
    // Clamp and sigmoid
    // ==============================

    always_comb begin
        if (pre > 16'sd127) begin
            clamped = 8'sh7f;
        end else if (pre < -16'sd128) begin
            clamped = 8'sh80;
        end else begin
            clamped = pre[rbm_pkg::DATA_W-1:0];
        end
    end

    // Magnitude in sixteenths, 128 fits unsigned
    assign mag = clamped[rbm_pkg::DATA_W-1] ? rbm_pkg::DATA_W'(-clamped)
                                            : rbm_pkg::DATA_W'(clamped);

    // Positive half, four linear segments
    always_comb begin
        if (mag >= 8'd80) begin
            f_pos = 16'hffff;
        end else if (mag >= 8'd38) begin
            f_pos = {1'b0, mag, 7'b0} + 16'd55296;
        end else if (mag >= 8'd16) begin
            f_pos = {mag[6:0], 9'b0} + 16'd40960;
        end else begin
            f_pos = {mag[5:0], 10'b0} + 16'd32768;
        end
    end

    // Mirror for negative inputs, 65536 - f
    assign prob = clamped[rbm_pkg::DATA_W-1] ? (~f_pos + 16'd1) : f_pos;

    always_ff @(posedge clk) begin
        if (pre_valid) begin
            sig <= prob;
        end
    end

    // ==============================
    // Sampling
    // ==============================

    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pre_valid    <= 1'b0;
            sig_valid    <= 1'b0;
            sample_valid <= 1'b0;
            sample       <= 1'b0;
            lfsr         <= SEED;
        end else begin
            pre_valid    <= ctrl.finish;
            sig_valid    <= pre_valid;
            sample_valid <= sig_valid;
            if (sig_valid) begin
                // Compare first, then advance once per sample
                sample <= (sig > lfsr);
                lfsr   <= {lfsr[14:0], lfsr_fb};
            end
        end
    end

endmodule

`default_nettype wire

/* source/rbm_sequencer.sv */
// ==============================
// Sequencer for the reconstruct run
// Weight array and bias storage with write port
// Run FSM and column counter
// Per-unit weight and bias feed
// ==============================

`timescale 1ns/100ps
`default_nettype none

module rbm_sequencer (
    input  wire                                             clk,
    input  wire                                             reset_n,
    input  wire                                             start,
    input  wire  [rbm_pkg::NUM_HIDDEN-1:0]                  hidden,
    input  wire                                             param_we,
    input  wire  rbm_pkg::param_write_t                     param,
    output logic                                            busy,
    output rbm_pkg::unit_ctrl_t                             ctrl,
    output rbm_pkg::unit_feed_t [rbm_pkg::NUM_VISIBLE-1:0]  feed
);

    localparam logic [rbm_pkg::COL_W-1:0] LAST_COL =
        rbm_pkg::COL_W'(rbm_pkg::NUM_HIDDEN - 1);

    // Second FINISH cycle, the last one before returning to IDLE
    localparam logic [rbm_pkg::COL_W-1:0] FINISH_END = rbm_pkg::COL_W'(1);

    rbm_pkg::seq_state_e state;
    logic [rbm_pkg::COL_W-1:0] col;
    logic [rbm_pkg::NUM_HIDDEN-1:0] hidden_r;

    logic signed [rbm_pkg::DATA_W-1:0] weights [rbm_pkg::NUM_VISIBLE][rbm_pkg::NUM_HIDDEN];
    logic signed [rbm_pkg::DATA_W-1:0] biases [rbm_pkg::NUM_VISIBLE];

    // ==============================
    // Parameter storage
    // ==============================

    // Writes only land while idle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int r = 0; r < rbm_pkg::NUM_VISIBLE; r++) begin
                biases[r] <= '0;
                for (int c = 0; c < rbm_pkg::NUM_HIDDEN; c++) begin
                    weights[r][c] <= '0;
                end
            end
        end else if (param_we && state == rbm_pkg::IDLE) begin
            if (param.target == rbm_pkg::WEIGHT) begin
                weights[param.row][param.col] <= param.data;
            end else begin
                biases[param.row] <= param.data;
            end
        end
    end

    // ==============================
    // Run FSM
    // ==============================

    // Column counter also times the two FINISH cycles
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= rbm_pkg::IDLE;
            col   <= '0;
        end else begin
            case (state)
                rbm_pkg::IDLE: begin
                    col <= '0;
                    if (start) begin
                        state <= rbm_pkg::ACCUM;
                    end
                end
                rbm_pkg::ACCUM: begin
                    // Wraps to 0 on the way into FINISH
                    col <= col + 1'b1;
                    if (col == LAST_COL) begin
                        state <= rbm_pkg::FINISH;
                    end
                end
                rbm_pkg::FINISH: begin
                    if (col == FINISH_END) begin
                        state <= rbm_pkg::IDLE;
                        col   <= '0;
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                default: begin
                    state <= rbm_pkg::IDLE;
                    col   <= '0;
                end
            endcase
        end
    end

    // Hidden vector sampled with an accepted start
    always_ff @(posedge clk) begin
        if (state == rbm_pkg::IDLE && start) begin
            hidden_r <= hidden;
        end
    end

    assign busy = (state != rbm_pkg::IDLE);

    // ==============================
    // Unit control and feed
    // ==============================

    always_comb begin
        // Units clear on the same edge that accepts start
        ctrl.clear      = (state == rbm_pkg::IDLE) && start;
        ctrl.accumulate = (state == rbm_pkg::ACCUM);
        ctrl.hidden_bit = hidden_r[col];
        ctrl.finish     = (state == rbm_pkg::FINISH) && (col == '0);
    end

    always_comb begin
        for (int k = 0; k < rbm_pkg::NUM_VISIBLE; k++) begin
            feed[k].weight = weights[k][col];
            feed[k].bias   = biases[k];
        end
    end

endmodule

`default_nettype wire

/* source/rbm_pkg.sv */
// ==============================
// Shared definitions for the RBM reconstruct phase
// Network sizes and fixed-point widths
// Sequencer state and parameter write opcode
// Parameter write, unit control and unit feed structs
// ==============================

`default_nettype none

package rbm_pkg;

    // ==============================
    // Sizes and widths
    // ==============================

    localparam int NUM_VISIBLE = 16;
    localparam int NUM_HIDDEN  = 16;

    // Weights and biases in 1-3-4 fixed point
    localparam int DATA_W = 8;
    localparam int ACC_W  = 16;

    // Sigmoid outputs and random numbers, fraction of 65536
    localparam int PROB_W = 16;

    localparam int ROW_W = 4;
    localparam int COL_W = 4;

    // Unit k starts from this value XOR k
    localparam logic [PROB_W-1:0] LFSR_SEED_BASE = 16'hACE1;

    // ==============================
    // Enums
    // ==============================

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ACCUM  = 2'd1,
        FINISH = 2'd2
    } seq_state_e;

    typedef enum logic {
        WEIGHT = 1'b0,
        BIAS   = 1'b1
    } param_target_e;

    // ==============================
    // Structs
    // ==============================

    // One write into the weight array or the bias vector
    typedef struct packed {
        param_target_e            target;
        logic [ROW_W-1:0]         row;
        // Ignored for bias writes
        logic [COL_W-1:0]         col;
        logic signed [DATA_W-1:0] data;
    } param_write_t;

    // Common to all units
    typedef struct packed {
        logic clear;
        logic accumulate;
        logic hidden_bit;
        logic finish;
    } unit_ctrl_t;

    // Per-unit operands for the current column
    typedef struct packed {
        logic signed [DATA_W-1:0] weight;
        logic signed [DATA_W-1:0] bias;
    } unit_feed_t;

endpackage

`default_nettype wire
